// File: Bender.yml
package:
  name: lc_unit

sources:
  - lc_pkg.sv
  - uinst_pkg.sv
  - uinst_decode.sv
  - lc_control.sv
  - lc_register.sv
  - macro_fetch.sv
  - lc_unit_top.sv
  - target: test
    files:
      - lc_unit_asserts.sv
      - tb_lc_unit.sv

// File: files.f
lc_pkg.sv
uinst_pkg.sv
uinst_decode.sv
lc_control.sv
lc_register.sv
macro_fetch.sv
lc_unit_top.sv
lc_unit_asserts.sv
tb_lc_unit.sv

// File: lc_control.sv
////////////////////////////////////////////////////////////////////////////
// LC control
// Fetch-need, increment, interrupt sample and shifter select terms
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lc_control (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              state_fetch,
   input  wire uinst_pkg::uctl_t  ctl,
   input  wire lc_pkg::lc_t       lc,
   input  wire lc_pkg::spc_t      spc,
   input  wire logic              ext_int,
   input  wire logic              bus_int,
   output lc_pkg::lcc_out_t       lcc
);

   logic newlc;
   logic next_instrd;
   logic sintr;

   logic lc0b;
   logic lcinc;
   logic needfetch;
   logic ifetch;
   logic have_wrong_word;
   logic last_byte_in_word;
   logic next_instr;
   logic newlc_in;
   logic inst_in_left_half;
   logic inst_in_2nd_or_4th_quarter;

   ////////////////////////////////////////////////////////////////////////////
   // Fetch and increment
   ////////////////////////////////////////////////////////////////////////////

   assign lc0b = lc[0] & ctl.lc_byte_mode;

   // Plain return to the next macroinstruction, not a source pop
   assign next_instr = ctl.spop & ~ctl.srcspcpopreal & spc[lc_pkg::SPC_RET_BIT];

   assign have_wrong_word   = newlc | ctl.destlc;
   assign last_byte_in_word = ~lc[1] & ~lc0b;
   assign needfetch         = have_wrong_word | last_byte_in_word;

   assign lcinc  = next_instrd | (ctl.irdisp & ctl.ir24);
   assign ifetch = needfetch & lcinc;

   // Wrong word stays pending until an increment fetches it
   assign newlc_in = have_wrong_word & ~lcinc;

   always_ff @(posedge clk) begin
      if (reset) begin
         newlc       <= 1'b0;
         next_instrd <= 1'b0;
         sintr       <= 1'b0;
      end else if (state_fetch) begin
         newlc       <= newlc_in;
         next_instrd <= next_instr;
         sintr       <= ext_int | bus_int;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Rotate adjust
   ////////////////////////////////////////////////////////////////////////////

   assign inst_in_left_half          = ~(lc[1] ^ lc0b) & ctl.mrot;
   assign inst_in_2nd_or_4th_quarter = ~lc[0] & ctl.mrot & ctl.lc_byte_mode;

   always_comb begin
      lcc           = '0;
      lcc.ifetch    = ifetch;
      lcc.lc0b      = lc0b;
      lcc.lcinc     = lcinc;
      lcc.needfetch = needfetch;
      lcc.sh3       = ctl.ir3 ^ inst_in_2nd_or_4th_quarter;
      lcc.sh4       = ctl.ir4 ^ inst_in_left_half;
      lcc.sintr     = sintr;
      // Force word select on a return while the word is already here
      lcc.spc1a     = (spc[lc_pkg::SPC_RET_BIT] & ~needfetch) |
                      spc[lc_pkg::SPC_WSEL_BIT];
   end

endmodule

`default_nettype wire

// File: lc_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Location counter package
// Widths and value types for LC, the micro stack word and LC control
////////////////////////////////////////////////////////////////////////////

package lc_pkg;

   // Location counter in bytes, word address drops the byte lanes
   localparam int LC_WIDTH   = 26;
   localparam int ADDR_WIDTH = LC_WIDTH - 2;

   localparam int SPC_WIDTH  = 19;
   localparam int WORD_WIDTH = 32;
   localparam int HALF_WIDTH = 16;

   // Micro stack word bit positions
   localparam int SPC_RET_BIT  = 14;
   localparam int SPC_WSEL_BIT = 1;

   typedef logic [LC_WIDTH-1:0]   lc_t;
   typedef logic [SPC_WIDTH-1:0]  spc_t;
   typedef logic [WORD_WIDTH-1:0] word_t;
   typedef logic [HALF_WIDTH-1:0] half_t;

   // LC control outputs
   typedef struct packed {
      logic ifetch;
      logic lc0b;
      logic lcinc;
      logic needfetch;
      logic sh3;
      logic sh4;
      logic sintr;
      logic spc1a;
   } lcc_out_t;

endpackage

// File: lc_register.sv
////////////////////////////////////////////////////////////////////////////
// Location counter register
// Load from the bus or step by a byte or a halfword on fetch cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lc_register (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              state_fetch,
   input  wire uinst_pkg::uctl_t  ctl,
   input  wire lc_pkg::lcc_out_t  lcc,
   input  wire lc_pkg::lc_t       bus,
   output lc_pkg::lc_t            lc
);

   lc_pkg::lc_t lc_q;
   lc_pkg::lc_t step;
   lc_pkg::lc_t lc_next;

   // One byte or one halfword per macroinstruction
   assign step = ctl.lc_byte_mode ? lc_pkg::lc_t'(1) : lc_pkg::lc_t'(2);

   always_comb begin
      lc_next = lc_q;
      if (ctl.destlc) begin
         lc_next = bus;
      end else if (lcc.lcinc) begin
         lc_next = lc_q + step;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lc_q <= '0;
      end else if (state_fetch) begin
         lc_q <= lc_next;
      end
   end

   assign lc = lc_q;

endmodule

`default_nettype wire

// File: lc_unit_asserts.sv
////////////////////////////////////////////////////////////////////////////
// LC control assertions
// Strobe relations and the reset value of the interrupt sample
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc_unit_asserts (
   input logic             clk,
   input logic             reset,
   input logic             state_fetch,
   input uinst_pkg::uctl_t ctl,
   input lc_pkg::lc_t      lc,
   input lc_pkg::spc_t     spc,
   input logic             ifetch,
   input logic             newlc,
   input logic             lcinc,
   input logic             sintr
);

   int   fail_count = 0;
   logic at_word_end;
   logic ret_seen;

   // Last macroinstruction of the word for the current mode
   assign at_word_end = ctl.lc_byte_mode ? (lc[1:0] == 2'b00) : !lc[1];

   // Return to the next macroinstruction seen on the last fetch edge
   always_ff @(posedge clk) begin
      if (reset) begin
         ret_seen <= 1'b0;
      end else if (state_fetch) begin
         ret_seen <= ctl.spop && !ctl.srcspcpopreal && spc[lc_pkg::SPC_RET_BIT];
      end
   end

   // A fetch only starts on a wrong word or at the end of the word
   a_ifetch_needs_fetch : assert property (@(posedge clk) disable iff (reset)
      ifetch |-> (newlc || ctl.destlc || at_word_end))
   else begin
      fail_count = fail_count + 1;
      $error("ifetch high while no fetch is needed");
   end

   // Increment comes from an earlier return or an advancing dispatch
   a_lcinc_source : assert property (@(posedge clk) disable iff (reset)
      lcinc |-> (ret_seen || (ctl.irdisp && ctl.ir24)))
   else begin
      fail_count = fail_count + 1;
      $error("lcinc high without a return or a dispatch");
   end

   a_sintr_reset : assert property (@(posedge clk) reset |=> !sintr)
   else begin
      fail_count = fail_count + 1;
      $error("sintr not cleared by reset");
   end

endmodule

bind lc_control lc_unit_asserts u_asserts (
   .clk         (clk),
   .reset       (reset),
   .state_fetch (state_fetch),
   .ctl         (ctl),
   .lc          (lc),
   .spc         (spc),
   .ifetch      (ifetch),
   .newlc       (newlc),
   .lcinc       (lcinc),
   .sintr       (sintr)
);

// File: lc_unit_top.sv
////////////////////////////////////////////////////////////////////////////
// Location counter unit
// Decode, LC control, LC register and macroinstruction fetch buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lc_unit_top (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         state_fetch,
   input  wire uinst_pkg::uinst_t            uinst,
   input  wire lc_pkg::lc_t                  bus,
   input  wire lc_pkg::spc_t                 spc,
   input  wire logic                         ext_int,
   input  wire logic                         bus_int,
   input  wire lc_pkg::word_t                mem_word,
   output lc_pkg::lc_t                       lc,
   output lc_pkg::lcc_out_t                  ctl_out,
   output logic [lc_pkg::ADDR_WIDTH-1:0]     mem_addr,
   output lc_pkg::half_t                     minst
);

   uinst_pkg::uctl_t ctl;
   lc_pkg::lcc_out_t lcc;

   uinst_decode u_decode (
      .clk   (clk),
      .reset (reset),
      .uinst (uinst),
      .ctl   (ctl)
   );

   lc_control u_control (
      .clk         (clk),
      .reset       (reset),
      .state_fetch (state_fetch),
      .ctl         (ctl),
      .lc          (lc),
      .spc         (spc),
      .ext_int     (ext_int),
      .bus_int     (bus_int),
      .lcc         (lcc)
   );

   lc_register u_register (
      .clk         (clk),
      .reset       (reset),
      .state_fetch (state_fetch),
      .ctl         (ctl),
      .lcc         (lcc),
      .bus         (bus),
      .lc          (lc)
   );

   macro_fetch u_fetch (
      .clk         (clk),
      .reset       (reset),
      .state_fetch (state_fetch),
      .lcc         (lcc),
      .lc          (lc),
      .mem_word    (mem_word),
      .mem_addr    (mem_addr),
      .minst       (minst)
   );

   assign ctl_out = lcc;

endmodule

`default_nettype wire

// File: macro_fetch.sv
////////////////////////////////////////////////////////////////////////////
// Macroinstruction fetch buffer
// Holds the fetched word, picks the halfword at LC, drives the word address
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module macro_fetch (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         state_fetch,
   input  wire lc_pkg::lcc_out_t             lcc,
   input  wire lc_pkg::lc_t                  lc,
   input  wire lc_pkg::word_t                mem_word,
   output logic [lc_pkg::ADDR_WIDTH-1:0]     mem_addr,
   output lc_pkg::half_t                     minst
);

   lc_pkg::word_t word_q;

   // Word address of the current LC
   assign mem_addr = lc[lc_pkg::LC_WIDTH-1:2];

   // Memory returns the word for mem_addr in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         word_q <= '0;
      end else if (state_fetch && lcc.ifetch) begin
         word_q <= mem_word;
      end
   end

   // LC bit 1 picks the upper halfword
   always_comb begin
      if (lc[1]) begin
         minst = word_q[lc_pkg::WORD_WIDTH-1:lc_pkg::HALF_WIDTH];
      end else begin
         minst = word_q[lc_pkg::HALF_WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

// File: tb_lc_unit.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the location counter unit
// Seeded random microinstructions checked against a cycle model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lc_unit;

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 3;
   localparam int          NUM_CYCLES   = 2000;
   localparam int          MAX_CYCLES   = NUM_CYCLES + RESET_CYCLES + 50;
   localparam logic [31:0] SEED         = 32'hb4c6faff;
   localparam int          LC_MSB       = lc_pkg::LC_WIDTH - 1;

   logic                          clk;
   logic                          reset;
   logic                          state_fetch;
   uinst_pkg::uinst_t             uinst;
   lc_pkg::lc_t                   bus;
   lc_pkg::spc_t                  spc;
   logic                          ext_int;
   logic                          bus_int;
   lc_pkg::word_t                 mem_word;
   lc_pkg::lc_t                   lc;
   lc_pkg::lcc_out_t              ctl_out;
   logic [lc_pkg::ADDR_WIDTH-1:0] mem_addr;
   lc_pkg::half_t                 minst;

   // Cycle model state
   uinst_pkg::uctl_t m_ctl;
   lc_pkg::lc_t      m_lc;
   logic             m_newlc;
   logic             m_next_instrd;
   logic             m_sintr;
   lc_pkg::word_t    m_word;

   lc_unit_top u_dut (
      .clk         (clk),
      .reset       (reset),
      .state_fetch (state_fetch),
      .uinst       (uinst),
      .bus         (bus),
      .spc         (spc),
      .ext_int     (ext_int),
      .bus_int     (bus_int),
      .mem_word    (mem_word),
      .lc          (lc),
      .ctl_out     (ctl_out),
      .mem_addr    (mem_addr),
      .minst       (minst)
   );

   // Memory contents, a hash of the full word address
   function automatic lc_pkg::word_t word_at(input logic [lc_pkg::ADDR_WIDTH-1:0] addr);
      lc_pkg::word_t a;
      a = lc_pkg::word_t'(addr);
      return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
   endfunction

   assign mem_word = word_at(mem_addr);

   function automatic uinst_pkg::uctl_t decode_uinst(input uinst_pkg::uinst_t u,
                                                     input logic mode);
      uinst_pkg::uctl_t c;
      c               = '0;
      c.destlc        = (u.op == uinst_pkg::UOP_LOAD_LC);
      c.irdisp        = (u.op == uinst_pkg::UOP_DISPATCH);
      c.spop          = (u.op == uinst_pkg::UOP_POPJ) || (u.op == uinst_pkg::UOP_POPJ_SRC);
      c.srcspcpopreal = (u.op == uinst_pkg::UOP_POPJ_SRC);
      c.ir24          = u.ir24;
      c.ir3           = u.ir3;
      c.ir4           = u.ir4;
      c.mrot          = u.mrot;
      if (u.op == uinst_pkg::UOP_SET_BYTE) begin
         c.lc_byte_mode = 1'b1;
      end else if (u.op == uinst_pkg::UOP_SET_HALF) begin
         c.lc_byte_mode = 1'b0;
      end else begin
         c.lc_byte_mode = mode;
      end
      return c;
   endfunction

   function automatic lc_pkg::lcc_out_t expect_lcc(input uinst_pkg::uctl_t c,
                                                   input lc_pkg::lc_t l,
                                                   input logic newlc,
                                                   input logic next_instrd,
                                                   input logic sintr,
                                                   input lc_pkg::spc_t s);
      lc_pkg::lcc_out_t o;
      logic             at_boundary;
      logic             left_half;
      o      = '0;
      o.lc0b = c.lc_byte_mode && l[0];
      // Byte position in the word decides the boundary and the rotate half
      if (c.lc_byte_mode) begin
         at_boundary = (l[1:0] == 2'b00);
         left_half   = (l[1:0] == 2'b00) || (l[1:0] == 2'b11);
      end else begin
         at_boundary = !l[1];
         left_half   = !l[1];
      end
      o.needfetch = newlc || c.destlc || at_boundary;
      o.lcinc     = next_instrd || (c.irdisp && c.ir24);
      o.ifetch    = o.needfetch && o.lcinc;
      o.sh3       = c.ir3 ^ (c.mrot && c.lc_byte_mode && !l[0]);
      o.sh4       = c.ir4 ^ (c.mrot && left_half);
      o.sintr     = sintr;
      o.spc1a     = s[lc_pkg::SPC_WSEL_BIT] || (s[lc_pkg::SPC_RET_BIT] && !o.needfetch);
      return o;
   endfunction

   task automatic stop_on_failure();
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_lc(input lc_pkg::lc_t got, input lc_pkg::lc_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_ctl(input lc_pkg::lcc_out_t got, input lc_pkg::lcc_out_t exp,
                            input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_minst(input lc_pkg::half_t got, input lc_pkg::half_t exp,
                              input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   // Model update on a clock edge, inputs are still the ones the DUT sampled
   task automatic step_model();
      lc_pkg::lcc_out_t o;
      if (reset) begin
         m_ctl         = '0;
         m_lc          = '0;
         m_newlc       = 1'b0;
         m_next_instrd = 1'b0;
         m_sintr       = 1'b0;
         m_word        = '0;
      end else begin
         o = expect_lcc(m_ctl, m_lc, m_newlc, m_next_instrd, m_sintr, spc);
         if (state_fetch) begin
            if (o.ifetch) begin
               m_word = word_at(m_lc[LC_MSB:2]);
            end
            m_newlc       = (m_newlc || m_ctl.destlc) && !o.lcinc;
            m_next_instrd = m_ctl.spop && !m_ctl.srcspcpopreal && spc[lc_pkg::SPC_RET_BIT];
            m_sintr       = ext_int || bus_int;
            if (m_ctl.destlc) begin
               m_lc = bus;
            end else if (o.lcinc) begin
               m_lc = m_lc + lc_pkg::lc_t'(m_ctl.lc_byte_mode ? 1 : 2);
            end
         end
         m_ctl = decode_uinst(uinst, m_ctl.lc_byte_mode);
      end
   endtask

   task automatic drive_random();
      uinst_pkg::uinst_t u;
      u.op   = uinst_pkg::uop_e'($urandom_range(6, 0));
      u.ir24 = ($urandom_range(3, 0) != 0);
      u.ir3  = 1'($urandom_range(1, 0));
      u.ir4  = 1'($urandom_range(1, 0));
      u.mrot = 1'($urandom_range(1, 0));
      u.rsvd = 1'($urandom_range(1, 0));
      uinst       <= u;
      bus         <= lc_pkg::lc_t'($urandom());
      spc         <= lc_pkg::spc_t'($urandom());
      ext_int     <= ($urandom_range(7, 0) == 0);
      bus_int     <= ($urandom_range(7, 0) == 0);
      state_fetch <= ($urandom_range(3, 0) != 0);
   endtask

   task automatic check_outputs();
      lc_pkg::lcc_out_t exp;
      exp = expect_lcc(m_ctl, m_lc, m_newlc, m_next_instrd, m_sintr, spc);
      check_lc(lc, m_lc, "lc");
      if (mem_addr !== m_lc[LC_MSB:2]) begin
         $display("MISMATCH at %0t: mem_addr is %h, expected %h", $time, mem_addr,
                  m_lc[LC_MSB:2]);
         stop_on_failure();
      end
      check_ctl(ctl_out, exp, "ctl_out");
      check_minst(minst, m_lc[1] ? m_word[31:16] : m_word[15:0], "minst");
      if (u_dut.u_control.u_asserts.fail_count != 0) begin
         $display("An assertion in lc_control failed before %0t", $time);
         stop_on_failure();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      int n;
      for (n = 0; n < MAX_CYCLES; n++) begin
         @(posedge clk);
      end
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      stop_on_failure();
   end

   initial begin : stimulus
      int cyc;
      void'($urandom(SEED));
      reset       = 1'b1;
      state_fetch = 1'b0;
      uinst       = '0;
      bus         = '0;
      spc         = '0;
      ext_int     = 1'b0;
      bus_int     = 1'b0;
      for (cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
         @(posedge clk);
         step_model();
         if (cyc == RESET_CYCLES - 1) begin
            reset <= 1'b0;
         end
         if (cyc >= RESET_CYCLES - 1) begin
            drive_random();
         end
         @(negedge clk);
         // Values straight out of reset
         if (cyc == RESET_CYCLES - 1) begin
            check_lc(lc, '0, "lc after reset");
            check_minst(minst, '0, "minst after reset");
            check_ctl(ctl_out, expect_lcc('0, '0, 1'b0, 1'b0, 1'b0, spc),
                      "ctl_out after reset");
         end
         check_outputs();
      end
      if (u_dut.u_control.u_asserts.fail_count == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Assertion failures were recorded during the run");
         stop_on_failure();
      end
   end

endmodule

// File: uinst_decode.sv
////////////////////////////////////////////////////////////////////////////
// Microinstruction decode
// Registers the opcode strobes and keeps the byte or halfword mode bit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uinst_decode (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire uinst_pkg::uinst_t uinst,
   output uinst_pkg::uctl_t       ctl
);

   uinst_pkg::uctl_t dec;
   uinst_pkg::uctl_t ctl_q;
   logic             byte_mode_next;

   // Mode bit only moves on the two set opcodes
   always_comb begin
      case (uinst.op)
         uinst_pkg::UOP_SET_BYTE: byte_mode_next = 1'b1;
         uinst_pkg::UOP_SET_HALF: byte_mode_next = 1'b0;
         default:                 byte_mode_next = ctl_q.lc_byte_mode;
      endcase
   end

   always_comb begin
      dec               = '0;
      dec.destlc        = (uinst.op == uinst_pkg::UOP_LOAD_LC);
      dec.irdisp        = (uinst.op == uinst_pkg::UOP_DISPATCH);
      dec.spop          = (uinst.op == uinst_pkg::UOP_POPJ) ||
                          (uinst.op == uinst_pkg::UOP_POPJ_SRC);
      dec.srcspcpopreal = (uinst.op == uinst_pkg::UOP_POPJ_SRC);
      // Field bits pass straight into the control word
      dec.ir24          = uinst.ir24;
      dec.ir3           = uinst.ir3;
      dec.ir4           = uinst.ir4;
      dec.mrot          = uinst.mrot;
      dec.lc_byte_mode  = byte_mode_next;
   end

   // Decode register, loads every cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         ctl_q <= '0;
      end else begin
         ctl_q <= dec;
      end
   end

   assign ctl = ctl_q;

endmodule

`default_nettype wire

// File: uinst_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Microinstruction package
// Opcode encoding, microinstruction fields and the decoded control word
////////////////////////////////////////////////////////////////////////////

package uinst_pkg;

   localparam int UOP_WIDTH = 3;

   typedef enum logic [UOP_WIDTH-1:0] {
      UOP_NOP      = 3'd0,
      UOP_LOAD_LC  = 3'd1,
      UOP_DISPATCH = 3'd2,
      UOP_POPJ     = 3'd3,
      UOP_POPJ_SRC = 3'd4,
      UOP_SET_BYTE = 3'd5,
      UOP_SET_HALF = 3'd6
   } uop_e;

   // Incoming microinstruction
   typedef struct packed {
      uop_e op;
      logic ir24;    // dispatch advances LC
      logic ir3;     // low rotate bit
      logic ir4;     // high rotate bit
      logic mrot;    // ir10 and ir11 both set
      logic rsvd;    // reserved, ignored by decode
   } uinst_t;

   // Decoded strobes for LC control and the LC register
   typedef struct packed {
      logic destlc;
      logic irdisp;
      logic ir24;
      logic spop;
      logic srcspcpopreal;
      logic ir3;
      logic ir4;
      logic mrot;
      logic lc_byte_mode;
   } uctl_t;

endpackage
